// File: Bender.yml
package:
  name: axis_out

export_include_dirs:
  - hdl

sources:
  - hdl/axis_out_pkg.sv
  - hdl/cdc_sync.sv
  - hdl/async_fifo.sv
  - hdl/axis_out_csr.sv
  - hdl/axis_out_tx.sv
  - hdl/axis_out.sv
  - target: test
    files:
      - testbench/axis_out_tb.sv

// File: hdl/async_fifo.sv
`timescale 1ns/100ps

module async_fifo #(
   parameter type data_t = logic [31:0],
   parameter int  ADDR_W = 4
) (
   // write side
   input  logic                       w_clk_i,
   input  logic                       w_reset_i,
   input  logic                       w_en_i,
   input  data_t                      w_data_i,
   output axis_out_pkg::fifo_status_t w_status_o,
   // read side
   input  logic                       r_clk_i,
   input  logic                       r_reset_i,
   input  logic                       r_en_i,
   output data_t                      r_data_o,
   output logic                       r_empty_o
);

   localparam int DEPTH = 2 ** ADDR_W;

   data_t mem [DEPTH];

   // pointers carry one extra bit to tell full from empty
   logic [ADDR_W:0] w_bin_q;
   logic [ADDR_W:0] w_gray_q;
   logic [ADDR_W:0] w_rgray_meta_q;
   logic [ADDR_W:0] w_rgray_q;
   logic [ADDR_W:0] w_rbin;
   logic [ADDR_W:0] w_level;
   logic [ADDR_W:0] w_bin_nxt;
   logic            w_full;
   logic            w_push;

   logic [ADDR_W:0] r_bin_q;
   logic [ADDR_W:0] r_gray_q;
   logic [ADDR_W:0] r_wgray_meta_q;
   logic [ADDR_W:0] r_wgray_q;
   logic [ADDR_W:0] r_bin_nxt;
   logic            r_empty;
   logic            r_pop;
   data_t           r_data_q;

   function automatic logic [ADDR_W:0] bin2gray(input logic [ADDR_W:0] bin);
      return (bin >> 1) ^ bin;
   endfunction

   function automatic logic [ADDR_W:0] gray2bin(input logic [ADDR_W:0] gray);
      logic [ADDR_W:0] bin;
      bin[ADDR_W] = gray[ADDR_W];
      for (int i = ADDR_W - 1; i >= 0; i--) begin
         bin[i] = bin[i+1] ^ gray[i];
      end
      return bin;
   endfunction

   // write clock domain

   assign w_rbin    = gray2bin(w_rgray_q);
   assign w_level   = w_bin_q - w_rbin;
   assign w_full    = (w_level == DEPTH[ADDR_W:0]);
   // writes into a full fifo are ignored
   assign w_push    = w_en_i & ~w_full;
   assign w_bin_nxt = w_bin_q + 1'b1;

   always_ff @(posedge w_clk_i) begin
      if (w_reset_i) begin
         w_bin_q  <= '0;
         w_gray_q <= '0;
      end else if (w_push) begin
         w_bin_q  <= w_bin_nxt;
         w_gray_q <= bin2gray(w_bin_nxt);
      end
   end

   // read pointer brought over in gray code
   always_ff @(posedge w_clk_i) begin
      if (w_reset_i) begin
         w_rgray_meta_q <= '0;
         w_rgray_q      <= '0;
      end else begin
         w_rgray_meta_q <= r_gray_q;
         w_rgray_q      <= w_rgray_meta_q;
      end
   end

   always_ff @(posedge w_clk_i) begin
      if (w_push) begin
         mem[w_bin_q[ADDR_W-1:0]] <= w_data_i;
      end
   end

   assign w_status_o = '{empty: (w_level == '0), full: w_full, level: w_level};

   // read clock domain

   assign r_empty   = (r_gray_q == r_wgray_q);
   assign r_pop     = r_en_i & ~r_empty;
   assign r_bin_nxt = r_bin_q + 1'b1;

   always_ff @(posedge r_clk_i) begin
      if (r_reset_i) begin
         r_bin_q  <= '0;
         r_gray_q <= '0;
      end else if (r_pop) begin
         r_bin_q  <= r_bin_nxt;
         r_gray_q <= bin2gray(r_bin_nxt);
      end
   end

   always_ff @(posedge r_clk_i) begin
      if (r_reset_i) begin
         r_wgray_meta_q <= '0;
         r_wgray_q      <= '0;
      end else begin
         r_wgray_meta_q <= w_gray_q;
         r_wgray_q      <= r_wgray_meta_q;
      end
   end

   // word is valid the cycle after the pop and held until the next one
   always_ff @(posedge r_clk_i) begin
      if (r_pop) begin
         r_data_q <= mem[r_bin_q[ADDR_W-1:0]];
      end
   end

   assign r_data_o  = r_data_q;
   assign r_empty_o = r_empty;

endmodule

// File: hdl/axis_out.sv
`timescale 1ns/100ps
`include "axis_out_defines.svh"

module axis_out (
   // system clock domain
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  axis_out_pkg::wb_req_t wb_req_i,
   output axis_out_pkg::wb_rsp_t wb_rsp_o,
   output logic                  interrupt_o,
   input  logic                  dma_tvalid_i,
   input  axis_out_pkg::word_t   dma_tdata_i,
   output logic                  dma_tready_o,
   // stream clock domain
   input  logic                  axis_clk_i,
   output logic                  axis_tvalid_o,
   output axis_out_pkg::word_t   axis_tdata_o,
   output logic                  axis_tlast_o,
   input  logic                  axis_tready_i
);

   import axis_out_pkg::*;

   axis_cfg_t    cfg;
   fifo_status_t fifo_status;
   logic         fifo_write;
   word_t        fifo_wdata;
   logic         fifo_w_reset;

   // {reset, soft reset, enable} on the stream clock
   logic [2:0]   axis_ctrl;
   word_t        axis_nwords;
   logic         axis_reset;
   logic         fifo_read;
   logic         fifo_empty;
   word_t        fifo_rdata;

   assign fifo_w_reset = reset_i | cfg.soft_reset;
   assign axis_reset   = axis_ctrl[2] | axis_ctrl[1];

   axis_out_csr csr_i (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .wb_req_i     (wb_req_i),
      .wb_rsp_o     (wb_rsp_o),
      .dma_tvalid_i (dma_tvalid_i),
      .dma_tdata_i  (dma_tdata_i),
      .dma_tready_o (dma_tready_o),
      .fifo_status_i(fifo_status),
      .fifo_write_o (fifo_write),
      .fifo_wdata_o (fifo_wdata),
      .cfg_o        (cfg),
      .interrupt_o  (interrupt_o)
   );

   // stream side stays in reset until the system reset has crossed over
   cdc_sync #(
      .WIDTH    (3),
      .RESET_VAL(3'b100)
   ) cfg_sync (
      .clk_i   (axis_clk_i),
      .reset_i (reset_i),
      .signal_i({reset_i, cfg.soft_reset, cfg.enable}),
      .signal_o(axis_ctrl)
   );

   // nwords only changes while disabled
   cdc_sync #(
      .WIDTH    (`AXIS_OUT_DATA_W),
      .RESET_VAL('0)
   ) nwords_sync (
      .clk_i   (axis_clk_i),
      .reset_i (reset_i),
      .signal_i(cfg.nwords),
      .signal_o(axis_nwords)
   );

   async_fifo #(
      .data_t(word_t),
      .ADDR_W(`AXIS_OUT_FIFO_ADDR_W)
   ) data_fifo (
      .w_clk_i   (clk_i),
      .w_reset_i (fifo_w_reset),
      .w_en_i    (fifo_write),
      .w_data_i  (fifo_wdata),
      .w_status_o(fifo_status),
      .r_clk_i   (axis_clk_i),
      .r_reset_i (axis_reset),
      .r_en_i    (fifo_read),
      .r_data_o  (fifo_rdata),
      .r_empty_o (fifo_empty)
   );

   axis_out_tx tx_i (
      .axis_clk_i   (axis_clk_i),
      .sync_reset_i (axis_reset),
      .enable_i     (axis_ctrl[0]),
      .nwords_i     (axis_nwords),
      .fifo_empty_i (fifo_empty),
      .fifo_data_i  (fifo_rdata),
      .fifo_read_o  (fifo_read),
      .axis_tvalid_o(axis_tvalid_o),
      .axis_tdata_o (axis_tdata_o),
      .axis_tlast_o (axis_tlast_o),
      .axis_tready_i(axis_tready_i)
   );

endmodule

// File: hdl/axis_out_csr.sv
`timescale 1ns/100ps
`include "axis_out_defines.svh"

module axis_out_csr (
   input  logic                       clk_i,
   input  logic                       reset_i,
   // wishbone slave
   input  axis_out_pkg::wb_req_t      wb_req_i,
   output axis_out_pkg::wb_rsp_t      wb_rsp_o,
   // dma input
   input  logic                       dma_tvalid_i,
   input  axis_out_pkg::word_t        dma_tdata_i,
   output logic                       dma_tready_o,
   // fifo write side
   input  axis_out_pkg::fifo_status_t fifo_status_i,
   output logic                       fifo_write_o,
   output axis_out_pkg::word_t        fifo_wdata_o,
   output axis_out_pkg::axis_cfg_t    cfg_o,
   output logic                       interrupt_o
);

   import axis_out_pkg::*;

   localparam int NBYTES = `AXIS_OUT_DATA_W / 8;

   axis_cfg_t cfg_q;
   word_t     threshold_q;
   logic      ack_q;
   word_t     rdata_q;
   word_t     reg_rdata;
   logic      access;
   logic      data_access;
   logic      cpu_write;

   function automatic word_t merge_bytes(input word_t old_val, input word_t new_val,
                                         input logic [NBYTES-1:0] sel);
      word_t merged;
      merged = old_val;
      for (int b = 0; b < NBYTES; b++) begin
         if (sel[b]) begin
            merged[8*b +: 8] = new_val[8*b +: 8];
         end
      end
      return merged;
   endfunction

   // new access, not yet acknowledged
   assign access      = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
   assign data_access = access & wb_req_i.we & (wb_req_i.adr == `AXIS_OUT_REG_DATA);

   // cpu word only goes in when the dma is idle and there is room
   assign cpu_write    = data_access & ~fifo_status_i.full & ~dma_tvalid_i;
   assign dma_tready_o = ~fifo_status_i.full & cfg_q.enable & ~cpu_write;

   assign fifo_write_o = cpu_write | (dma_tvalid_i & dma_tready_o);
   assign fifo_wdata_o = cpu_write ? wb_req_i.dat : dma_tdata_i;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         ack_q <= 1'b0;
      end else begin
         // data writes wait here while the fifo is full
         ack_q <= cpu_write | (access & ~data_access);
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         cfg_q       <= '0;
         threshold_q <= '0;
      end else if (access && wb_req_i.we) begin
         case (wb_req_i.adr)
            `AXIS_OUT_REG_SOFT_RESET: if (wb_req_i.sel[0]) cfg_q.soft_reset <= wb_req_i.dat[0];
            `AXIS_OUT_REG_ENABLE:     if (wb_req_i.sel[0]) cfg_q.enable <= wb_req_i.dat[0];
            `AXIS_OUT_REG_NWORDS:
               cfg_q.nwords <= merge_bytes(cfg_q.nwords, wb_req_i.dat, wb_req_i.sel);
            `AXIS_OUT_REG_THRESHOLD:
               threshold_q <= merge_bytes(threshold_q, wb_req_i.dat, wb_req_i.sel);
            default: ;
         endcase
      end
   end

   always_comb begin
      case (wb_req_i.adr)
         `AXIS_OUT_REG_SOFT_RESET: reg_rdata = word_t'(cfg_q.soft_reset);
         `AXIS_OUT_REG_ENABLE:     reg_rdata = word_t'(cfg_q.enable);
         `AXIS_OUT_REG_NWORDS:     reg_rdata = cfg_q.nwords;
         `AXIS_OUT_REG_THRESHOLD:  reg_rdata = threshold_q;
         `AXIS_OUT_REG_STATUS:     reg_rdata = word_t'({fifo_status_i.full, fifo_status_i.empty});
         `AXIS_OUT_REG_LEVEL:      reg_rdata = word_t'(fifo_status_i.level);
         default:                  reg_rdata = '0;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (access && !wb_req_i.we) begin
         rdata_q <= reg_rdata;
      end
   end

   assign wb_rsp_o = '{ack: ack_q, dat: rdata_q};

   // level interrupt, stays up while the fifo runs low
   assign interrupt_o = (word_t'(fifo_status_i.level) <= threshold_q);

   assign cfg_o = cfg_q;

endmodule

// File: hdl/axis_out_defines.svh
`ifndef AXIS_OUT_DEFINES_SVH
`define AXIS_OUT_DEFINES_SVH

// stream word width, also the wishbone data width
`define AXIS_OUT_DATA_W 32

// fifo holds 2**ADDR_W words
`define AXIS_OUT_FIFO_ADDR_W 4

// register byte offsets on the wishbone port
// data is write only and feeds the fifo
`define AXIS_OUT_REG_DATA        8'h00
`define AXIS_OUT_REG_SOFT_RESET  8'h04
`define AXIS_OUT_REG_ENABLE      8'h08
`define AXIS_OUT_REG_NWORDS      8'h0C
`define AXIS_OUT_REG_THRESHOLD   8'h10

// read only status
// bit 0 empty, bit 1 full
`define AXIS_OUT_REG_STATUS      8'h14
`define AXIS_OUT_REG_LEVEL       8'h18

`endif

// File: hdl/axis_out_pkg.sv
`include "axis_out_defines.svh"

package axis_out_pkg;

   // one stream word
   typedef logic [`AXIS_OUT_DATA_W-1:0] word_t;

   // wishbone classic request, held by the master until ack
   typedef struct packed {
      logic                          cyc;
      logic                          stb;
      logic                          we;
      logic [7:0]                    adr;
      word_t                         dat;
      logic [`AXIS_OUT_DATA_W/8-1:0] sel;
   } wb_req_t;

   // wishbone response, ack lasts one cycle
   typedef struct packed {
      logic  ack;
      word_t dat;
   } wb_rsp_t;

   // software settings that go over to the stream clock
   typedef struct packed {
      logic  soft_reset;
      logic  enable;
      word_t nwords;
   } axis_cfg_t;

   // fifo state as seen from the write clock
   typedef struct packed {
      logic                            empty;
      logic                            full;
      logic [`AXIS_OUT_FIFO_ADDR_W:0]  level;
   } fifo_status_t;

endpackage

// File: hdl/axis_out_tx.sv
`timescale 1ns/100ps

module axis_out_tx (
   input  logic                axis_clk_i,
   input  logic                sync_reset_i,
   input  logic                enable_i,
   input  axis_out_pkg::word_t nwords_i,
   // fifo read side
   input  logic                fifo_empty_i,
   input  axis_out_pkg::word_t fifo_data_i,
   output logic                fifo_read_o,
   // axi-stream master
   output logic                axis_tvalid_o,
   output axis_out_pkg::word_t axis_tdata_o,
   output logic                axis_tlast_o,
   input  logic                axis_tready_i
);

   import axis_out_pkg::*;

   localparam logic ST_IDLE = 1'b0;
   localparam logic ST_SEND = 1'b1;

   logic  state_q;
   logic  state_d;
   // number of the beat on the bus, counted from 1
   word_t beat_q;
   logic  frame_end;
   logic  beat_done;

   always_comb begin
      state_d     = state_q;
      fifo_read_o = 1'b0;
      case (state_q)
         ST_IDLE: begin
            if (enable_i && !fifo_empty_i) begin
               fifo_read_o = 1'b1;
               state_d     = ST_SEND;
            end
         end
         default: begin
            // fetch the next word in the same cycle as the handshake
            if (axis_tready_i) begin
               if (enable_i && !fifo_empty_i) begin
                  fifo_read_o = 1'b1;
               end else begin
                  state_d = ST_IDLE;
               end
            end
         end
      endcase
   end

   always_ff @(posedge axis_clk_i) begin
      if (sync_reset_i) begin
         state_q <= ST_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   assign beat_done = axis_tvalid_o & axis_tready_i;
   // nwords of zero disables tlast
   assign frame_end = (nwords_i != '0) && (beat_q >= nwords_i);

   always_ff @(posedge axis_clk_i) begin
      if (sync_reset_i) begin
         beat_q <= word_t'(1);
      end else if (beat_done) begin
         beat_q <= frame_end ? word_t'(1) : beat_q + 1'b1;
      end
   end

   assign axis_tvalid_o = (state_q == ST_SEND);
   assign axis_tdata_o  = fifo_data_i;
   assign axis_tlast_o  = axis_tvalid_o & frame_end;

endmodule

// File: hdl/cdc_sync.sv
`timescale 1ns/100ps

module cdc_sync #(
   parameter int               WIDTH     = 1,
   parameter logic [WIDTH-1:0] RESET_VAL = '0
) (
   input  logic             clk_i,
   input  logic             reset_i,
   input  logic [WIDTH-1:0] signal_i,
   output logic [WIDTH-1:0] signal_o
);

   // first stage may go metastable, second one settles it
   logic [WIDTH-1:0] meta_q;
   logic [WIDTH-1:0] sync_q;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         meta_q <= RESET_VAL;
         sync_q <= RESET_VAL;
      end else begin
         meta_q <= signal_i;
         sync_q <= meta_q;
      end
   end

   assign signal_o = sync_q;

endmodule

// File: project.f
+incdir+hdl
hdl/axis_out_pkg.sv
hdl/cdc_sync.sv
hdl/async_fifo.sv
hdl/axis_out_csr.sv
hdl/axis_out_tx.sv
hdl/axis_out.sv
testbench/axis_out_tb.sv

// File: testbench/axis_out_tb.sv
`timescale 1ns/100ps
`include "axis_out_defines.svh"

module axis_out_tb;

   import axis_out_pkg::*;

   localparam real CLK_PERIOD      = 8.0;
   localparam real AXIS_PERIOD     = 11.0;
   localparam int  SEED            = 53849;
   localparam int  CYCLES_PER_STEP = 200;
   // covers a gray pointer crossing to the stream side and back
   localparam int  SETTLE_CYCLES   = 8;
   localparam int  STALL_CYCLES    = 16;

   localparam logic [1:0] READY_LOW    = 2'd0;
   localparam logic [1:0] READY_HIGH   = 2'd1;
   localparam logic [1:0] READY_RANDOM = 2'd2;

   typedef enum logic [2:0] {
      OP_WRITE, OP_READ, OP_CPU_BURST, OP_DMA_BURST,
      OP_WAIT_IDLE, OP_TREADY, OP_DMA_READY, OP_STALL_WRITE
   } op_e;

   typedef struct packed {
      op_e        op;
      logic [7:0] adr;
      word_t      dat;
   } step_t;

   logic    clk;
   logic    reset;
   logic    axis_clk;
   wb_req_t wb_req;
   wb_rsp_t wb_rsp;
   logic    interrupt;
   logic    dma_tvalid;
   word_t   dma_tdata;
   logic    dma_tready;
   logic    axis_tvalid;
   word_t   axis_tdata;
   logic    axis_tlast;
   logic    axis_tready;

   step_t      steps[$];
   string      step_names[$];
   word_t      expected_q[$];
   string      current_name;
   int         seed;
   logic [1:0] ready_mode;
   word_t      nwords_model;
   word_t      threshold_model;
   int         beat_count;
   int         cycle_count = 0;
   int         cycle_limit = 0;

   axis_out dut_i (
      .clk_i        (clk),
      .reset_i      (reset),
      .wb_req_i     (wb_req),
      .wb_rsp_o     (wb_rsp),
      .interrupt_o  (interrupt),
      .dma_tvalid_i (dma_tvalid),
      .dma_tdata_i  (dma_tdata),
      .dma_tready_o (dma_tready),
      .axis_clk_i   (axis_clk),
      .axis_tvalid_o(axis_tvalid),
      .axis_tdata_o (axis_tdata),
      .axis_tlast_o (axis_tlast),
      .axis_tready_i(axis_tready)
   );

   always #(CLK_PERIOD / 2.0) clk = ~clk;
   always #(AXIS_PERIOD / 2.0) axis_clk = ~axis_clk;

   task automatic stop_with_error(input string msg);
      $display("%s", msg);
      $display("Done: errors found");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_value(input string name, input word_t expected, input word_t actual);
      if (expected !== actual) begin
         stop_with_error($sformatf("CHECK FAILED %s: expected 0x%08h, actual 0x%08h",
                                   name, expected, actual));
      end
   endtask

   // all tasks start and end 1 ns after a rising system clock edge
   task automatic wb_start(input logic write_en, input logic [7:0] addr, input word_t wdata);
      wb_req = '{cyc: 1'b1, stb: 1'b1, we: write_en, adr: addr, dat: wdata, sel: '1};
   endtask

   task automatic wb_finish(output word_t rdata);
      @(negedge clk);
      while (!wb_rsp.ack) begin
         @(negedge clk);
      end
      rdata = wb_rsp.dat;
      @(posedge clk);
      #1;
      wb_req = '0;
   endtask

   task automatic wb_access(input logic write_en, input logic [7:0] addr, input word_t wdata,
                            output word_t rdata);
      wb_start(write_en, addr, wdata);
      wb_finish(rdata);
   endtask

   task automatic cpu_burst(input int count);
      word_t word;
      word_t rdata;
      for (int i = 0; i < count; i++) begin
         word = $random(seed);
         expected_q.push_back(word);
         wb_access(1'b1, `AXIS_OUT_REG_DATA, word, rdata);
      end
   endtask

   task automatic dma_burst(input int count);
      for (int i = 0; i < count; i++) begin
         dma_tdata  = $random(seed);
         dma_tvalid = 1'b1;
         @(negedge clk);
         while (!dma_tready) begin
            @(negedge clk);
         end
         // transfer happens on the coming edge
         expected_q.push_back(dma_tdata);
         @(posedge clk);
         #1;
      end
      dma_tvalid = 1'b0;
   endtask

   task automatic wait_idle();
      @(negedge clk);
      while (expected_q.size() != 0 || axis_tvalid) begin
         @(negedge clk);
      end
      repeat (SETTLE_CYCLES) @(posedge clk);
      #1;
   endtask

   // data write into a full fifo, released by opening tready
   task automatic stall_write(input string name);
      word_t word;
      word_t rdata;
      word = $random(seed);
      expected_q.push_back(word);
      wb_start(1'b1, `AXIS_OUT_REG_DATA, word);
      repeat (STALL_CYCLES) begin
         @(negedge clk);
         check_value({name, " ack while full"}, '0, word_t'(wb_rsp.ack));
      end
      @(posedge clk);
      #1;
      ready_mode = READY_HIGH;
      wb_finish(rdata);
   endtask

   task automatic run_step(input step_t s, input string name);
      word_t rdata;
      case (s.op)
         OP_WRITE: begin
            wb_access(1'b1, s.adr, s.dat, rdata);
            if (s.adr == `AXIS_OUT_REG_NWORDS) begin
               nwords_model = s.dat;
               beat_count   = 0;
            end
            if (s.adr == `AXIS_OUT_REG_THRESHOLD) begin
               threshold_model = s.dat;
            end
            if (s.adr == `AXIS_OUT_REG_SOFT_RESET && s.dat[0]) begin
               expected_q.delete();
               beat_count = 0;
            end
         end
         OP_READ: begin
            wb_access(1'b0, s.adr, '0, rdata);
            check_value(name, s.dat, rdata);
            if (s.adr == `AXIS_OUT_REG_LEVEL) begin
               @(negedge clk);
               check_value({name, " interrupt"}, word_t'(s.dat <= threshold_model),
                           word_t'(interrupt));
               @(posedge clk);
               #1;
            end
         end
         OP_CPU_BURST: cpu_burst(s.dat);
         OP_DMA_BURST: dma_burst(s.dat);
         OP_WAIT_IDLE: wait_idle();
         OP_TREADY:    ready_mode = s.dat[1:0];
         OP_DMA_READY: begin
            @(negedge clk);
            check_value(name, s.dat, word_t'(dma_tready));
            @(posedge clk);
            #1;
         end
         default: stall_write(name);
      endcase
   endtask

   task automatic add_step(input op_e op, input logic [7:0] adr, input word_t dat,
                           input string name);
      steps.push_back('{op: op, adr: adr, dat: dat});
      step_names.push_back(name);
   endtask

   task automatic build_table();
      add_step(OP_READ,      `AXIS_OUT_REG_STATUS,     1,  "reset_status");
      add_step(OP_READ,      `AXIS_OUT_REG_LEVEL,      0,  "reset_level");
      add_step(OP_DMA_READY, 8'h00,                    0,  "dma_ready_disabled");
      add_step(OP_WRITE,     `AXIS_OUT_REG_NWORDS,     4,  "nwords_4");
      add_step(OP_READ,      `AXIS_OUT_REG_NWORDS,     4,  "nwords_4_readback");
      add_step(OP_WRITE,     `AXIS_OUT_REG_ENABLE,     1,  "enable_on");
      add_step(OP_CPU_BURST, 8'h00,                    8,  "cpu_frames_4");
      add_step(OP_WAIT_IDLE, 8'h00,                    0,  "cpu_frames_4_drain");
      // frame length only changes while disabled
      add_step(OP_WRITE,     `AXIS_OUT_REG_ENABLE,     0,  "enable_off");
      add_step(OP_WRITE,     `AXIS_OUT_REG_NWORDS,     3,  "nwords_3");
      add_step(OP_WRITE,     `AXIS_OUT_REG_ENABLE,     1,  "enable_on_again");
      add_step(OP_CPU_BURST, 8'h00,                    3,  "cpu_frames_3");
      add_step(OP_DMA_BURST, 8'h00,                    6,  "dma_after_cpu");
      add_step(OP_WAIT_IDLE, 8'h00,                    0,  "mixed_drain");
      add_step(OP_TREADY,    8'h00,           READY_RANDOM, "tready_random");
      add_step(OP_CPU_BURST, 8'h00,                    6,  "random_ready_cpu");
      // odd total, so the frame is open when the soft reset hits
      add_step(OP_DMA_BURST, 8'h00,                    13, "random_ready_dma");
      add_step(OP_WAIT_IDLE, 8'h00,                    0,  "random_ready_drain");
      // frozen fifo for the level interrupt
      add_step(OP_WRITE,     `AXIS_OUT_REG_ENABLE,     0,  "enable_off_irq");
      add_step(OP_DMA_READY, 8'h00,                    0,  "dma_ready_disabled_again");
      add_step(OP_TREADY,    8'h00,            READY_LOW,  "tready_low");
      add_step(OP_WRITE,     `AXIS_OUT_REG_THRESHOLD,  2,  "threshold_2");
      add_step(OP_CPU_BURST, 8'h00,                    2,  "irq_fill_2");
      add_step(OP_READ,      `AXIS_OUT_REG_LEVEL,      2,  "irq_at_threshold");
      add_step(OP_CPU_BURST, 8'h00,                    1,  "irq_fill_3");
      add_step(OP_READ,      `AXIS_OUT_REG_LEVEL,      3,  "irq_above_threshold");
      // one word held by the sequencer, sixteen in the fifo
      add_step(OP_WRITE,     `AXIS_OUT_REG_ENABLE,     1,  "enable_on_fill");
      add_step(OP_CPU_BURST, 8'h00,                    14, "fill");
      add_step(OP_READ,      `AXIS_OUT_REG_STATUS,     2,  "full_status");
      add_step(OP_READ,      `AXIS_OUT_REG_LEVEL,      16, "full_level");
      add_step(OP_DMA_READY, 8'h00,                    0,  "dma_ready_full");
      add_step(OP_STALL_WRITE, 8'h00,                  0,  "stalled_write");
      add_step(OP_WAIT_IDLE, 8'h00,                    0,  "stall_drain");
      // queued words are dropped by the soft reset
      add_step(OP_TREADY,    8'h00,            READY_LOW,  "tready_low_stale");
      add_step(OP_CPU_BURST, 8'h00,                    5,  "stale_words");
      add_step(OP_WRITE,     `AXIS_OUT_REG_SOFT_RESET, 1,  "soft_reset_on");
      add_step(OP_WAIT_IDLE, 8'h00,                    0,  "soft_reset_settle");
      add_step(OP_WRITE,     `AXIS_OUT_REG_SOFT_RESET, 0,  "soft_reset_off");
      add_step(OP_READ,      `AXIS_OUT_REG_STATUS,     1,  "soft_reset_empty");
      add_step(OP_READ,      `AXIS_OUT_REG_LEVEL,      0,  "soft_reset_level");
      add_step(OP_TREADY,    8'h00,           READY_HIGH,  "tready_high");
      add_step(OP_CPU_BURST, 8'h00,                    4,  "after_soft_reset");
      add_step(OP_WAIT_IDLE, 8'h00,                    0,  "after_soft_reset_drain");
      add_step(OP_READ,      `AXIS_OUT_REG_STATUS,     1,  "final_empty");
   endtask

   // tready changes just after the stream clock edge
   always @(posedge axis_clk) begin : tready_driver
      logic [31:0] rnd;
      #1;
      case (ready_mode)
         READY_LOW:  axis_tready = 1'b0;
         READY_HIGH: axis_tready = 1'b1;
         default: begin
            rnd         = $random(seed);
            axis_tready = rnd[0];
         end
      endcase
   end

   // beats are sampled half a cycle before the edge that takes them
   always @(negedge axis_clk) begin : stream_monitor
      word_t exp_word;
      if (axis_tvalid === 1'b1 && axis_tready === 1'b1) begin
         if (expected_q.size() == 0) begin
            stop_with_error($sformatf("unexpected stream beat 0x%08h during %s",
                                      axis_tdata, current_name));
         end else begin
            beat_count++;
            exp_word = expected_q.pop_front();
            check_value($sformatf("%s beat %0d tdata", current_name, beat_count),
                        exp_word, axis_tdata);
            check_value($sformatf("%s beat %0d tlast", current_name, beat_count),
                        word_t'((nwords_model != 0) && (beat_count % nwords_model == 0)),
                        word_t'(axis_tlast));
         end
      end
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_limit > 0 && cycle_count > cycle_limit) begin
         stop_with_error($sformatf("timeout: run did not finish within %0d clock cycles",
                                   cycle_limit));
      end
   end

   initial begin
      clk             = 1'b0;
      axis_clk        = 1'b0;
      reset           = 1'b1;
      wb_req          = '0;
      dma_tvalid      = 1'b0;
      dma_tdata       = '0;
      axis_tready     = 1'b0;
      seed            = SEED;
      ready_mode      = READY_HIGH;
      nwords_model    = '0;
      threshold_model = '0;
      beat_count      = 0;
      current_name    = "reset";
      build_table();
      cycle_limit = steps.size() * CYCLES_PER_STEP;
      repeat (5) @(posedge clk);
      #1;
      reset = 1'b0;
      foreach (steps[i]) begin
         current_name = step_names[i];
         run_step(steps[i], step_names[i]);
      end
      $display("Done: no errors");
      $finish;
   end

endmodule
